// File: hdl/div_pkg.sv
`default_nettype none

package div_pkg;

	localparam int DIV_WIDTH = 64;
	localparam int DIV_STEPS = DIV_WIDTH; // one quotient bit per step
	localparam int DIV_CNT_W = $clog2(DIV_STEPS);

	typedef enum logic {
		DIV_OP_SIGNED   = 1'b0,
		DIV_OP_UNSIGNED = 1'b1
	} div_op_e;

	// single STEP state, the step counter decides when to leave it
	typedef enum logic [2:0] {
		IDLE = 3'd0,
		LOAD = 3'd1,
		STEP = 3'd2,
		FIX  = 3'd3,
		ACK  = 3'd4
	} div_state_e;

	// request from the execute stage
	typedef struct packed {
		div_op_e                op;
		logic [DIV_WIDTH-1:0]   dividend;
		logic [DIV_WIDTH-1:0]   divisor;
	} div_req_t;

	// signed results, held while ack is high
	typedef struct packed {
		logic [DIV_WIDTH-1:0]   quotient;
		logic [DIV_WIDTH-1:0]   remainder;
		logic                   div_by_zero;
	} div_rsp_t;

	// unsigned operands for the restoring datapath
	typedef struct packed {
		logic [DIV_WIDTH-1:0]   dividend_mag;
		logic [DIV_WIDTH-1:0]   divisor_mag;
	} div_mag_t;

endpackage

`default_nettype wire

// File: hdl/div_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module div_ctrl (
	input  wire  clk,
	input  wire  rst_n_i,
	input  logic req_i,
	input  logic last_i,
	output logic load_o,
	output logic step_o,
	output logic fix_o,
	output logic ack_o
);

	import div_pkg::*;

	div_state_e state_q;
	div_state_e next_state;
	logic       ack_q;
	logic       ack_d;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			ack_q   <= 1'b0;
		end else begin
			state_q <= next_state;
			ack_q   <= ack_d;
		end
	end

	always_comb begin
		next_state = state_q;
		case (state_q)
			IDLE: begin
				if (req_i) begin
					next_state = LOAD;
				end
			end
			LOAD: begin
				next_state = STEP;
			end
			STEP: begin
				if (last_i) begin // final quotient bit this cycle
					next_state = FIX;
				end
			end
			FIX: begin
				next_state = ACK;
			end
			ACK: begin
				// requester holds req for back-pressure
				if (!req_i) begin
					next_state = IDLE;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	// rsp is already registered when ACK is entered, ack follows a cycle later
	// and drops on the same edge that returns to IDLE
	assign ack_d = (state_q == ACK) && req_i;

	assign load_o = (state_q == LOAD);
	assign step_o = (state_q == STEP);
	assign fix_o  = (state_q == FIX);
	assign ack_o  = ack_q;

endmodule

`default_nettype wire

// File: hdl/div_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module div_step_counter (
	input  wire  clk,
	input  wire  rst_n_i,
	input  logic load_i,
	input  logic step_i,
	output logic last_o
);

	import div_pkg::*;

	logic [DIV_CNT_W-1:0] cnt_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
		end else if (load_i) begin
			cnt_q <= DIV_CNT_W'(DIV_STEPS - 1);
		end else if (step_i) begin
			cnt_q <= cnt_q - 1'b1; // wraps after the last step, unused then
		end
	end

	assign last_o = (cnt_q == '0);

endmodule

`default_nettype wire

// File: hdl/div_sign_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_sign_unit (
	input  wire                            clk,
	input  wire                            rst_n_i,
	input  div_pkg::div_req_t              req_i,
	input  logic                           load_i,
	input  logic                           fix_i,
	output div_pkg::div_mag_t              mag_o,
	input  logic [div_pkg::DIV_WIDTH-1:0]  quotient_mag_i,
	input  logic [div_pkg::DIV_WIDTH-1:0]  remainder_mag_i,
	output div_pkg::div_rsp_t              rsp_o
);

	import div_pkg::*;

	logic     is_signed;
	logic     dividend_neg;
	logic     divisor_neg;
	logic     divisor_zero;
	logic     q_neg_q;
	logic     r_neg_q;
	logic     dbz_q;
	div_rsp_t rsp_q;

	assign is_signed    = (req_i.op == DIV_OP_SIGNED);
	assign dividend_neg = is_signed && req_i.dividend[DIV_WIDTH-1];
	assign divisor_neg  = is_signed && req_i.divisor[DIV_WIDTH-1];
	assign divisor_zero = (req_i.divisor == '0);

	// magnitudes go straight to the datapath, which takes them on load
	assign mag_o.dividend_mag = dividend_neg ? -req_i.dividend : req_i.dividend;
	assign mag_o.divisor_mag  = divisor_neg ? -req_i.divisor : req_i.divisor;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			q_neg_q <= 1'b0;
			r_neg_q <= 1'b0;
			dbz_q   <= 1'b0;
		end else if (load_i) begin
			// x/0 keeps the all ones quotient unsigned
			q_neg_q <= (dividend_neg ^ divisor_neg) && !divisor_zero;
			r_neg_q <= dividend_neg; // remainder follows the dividend
			dbz_q   <= divisor_zero;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rsp_q <= '0;
		end else if (fix_i) begin
			rsp_q.quotient    <= q_neg_q ? -quotient_mag_i : quotient_mag_i;
			rsp_q.remainder   <= r_neg_q ? -remainder_mag_i : remainder_mag_i;
			rsp_q.div_by_zero <= dbz_q;
		end
	end

	assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// File: hdl/div_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module div_datapath (
	input  wire                            clk,
	input  wire                            rst_n_i,
	input  div_pkg::div_mag_t              mag_i,
	input  logic                           load_i,
	input  logic                           step_i,
	output logic [div_pkg::DIV_WIDTH-1:0]  quotient_mag_o,
	output logic [div_pkg::DIV_WIDTH-1:0]  remainder_mag_o
);

	import div_pkg::*;

	logic [DIV_WIDTH:0]   rem_q;  // partial remainder
	logic [DIV_WIDTH-1:0] quo_q;  // dividend bits out, quotient bits in
	logic [DIV_WIDTH-1:0] div_q;
	logic [DIV_WIDTH+1:0] rem_shift;
	logic [DIV_WIDTH+1:0] trial;
	logic                 trial_neg;

	// bring down the next dividend bit
	assign rem_shift = {rem_q, quo_q[DIV_WIDTH-1]};

	// trial subtract, wide enough that the top bit is a true sign
	assign trial     = rem_shift - {2'b00, div_q};
	assign trial_neg = trial[DIV_WIDTH+1];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rem_q <= '0;
			quo_q <= '0;
			div_q <= '0;
		end else if (load_i) begin
			rem_q <= '0;
			quo_q <= mag_i.dividend_mag;
			div_q <= mag_i.divisor_mag;
		end else if (step_i) begin
			if (trial_neg) begin
				rem_q <= rem_shift[DIV_WIDTH:0]; // restore
				quo_q <= {quo_q[DIV_WIDTH-2:0], 1'b0};
			end else begin
				rem_q <= trial[DIV_WIDTH:0];
				quo_q <= {quo_q[DIV_WIDTH-2:0], 1'b1};
			end
		end
	end

	// remainder is always below the divisor, top bit stays clear
	assign quotient_mag_o  = quo_q;
	assign remainder_mag_o = rem_q[DIV_WIDTH-1:0];

endmodule

`default_nettype wire

// File: hdl/int_div_top.sv
`timescale 1ns/1ps
`default_nettype none

module int_div_top (
	input  wire                clk,
	input  wire                rst_n_i,
	input  logic               req_i,
	input  div_pkg::div_req_t  req_data_i,
	output logic               ack_o,
	output div_pkg::div_rsp_t  rsp_o
);

	import div_pkg::*;

	logic                 load;
	logic                 step;
	logic                 fix;
	logic                 last;
	div_mag_t             mag;
	logic [DIV_WIDTH-1:0] quotient_mag;
	logic [DIV_WIDTH-1:0] remainder_mag;

	div_ctrl i_ctrl (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (req_i),
		.last_i  (last),
		.load_o  (load),
		.step_o  (step),
		.fix_o   (fix),
		.ack_o   (ack_o)
	);

	div_step_counter i_step_counter (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.load_i  (load),
		.step_i  (step),
		.last_o  (last)
	);

	// request is only sampled while load is high
	div_sign_unit i_sign_unit (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.req_i           (req_data_i),
		.load_i          (load),
		.fix_i           (fix),
		.mag_o           (mag),
		.quotient_mag_i  (quotient_mag),
		.remainder_mag_i (remainder_mag),
		.rsp_o           (rsp_o)
	);

	div_datapath i_datapath (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.mag_i           (mag),
		.load_i          (load),
		.step_i          (step),
		.quotient_mag_o  (quotient_mag),
		.remainder_mag_o (remainder_mag)
	);

endmodule

`default_nettype wire

// File: testbench/int_div_assert.sv
`timescale 1ns/1ps
`default_nettype none

module int_div_assert (
	input  wire                clk,
	input  wire                rst_n_i,
	input  logic               req_i,
	input  logic               ack_o,
	input  div_pkg::div_rsp_t  rsp_o
);

	property ack_low_in_reset;
		@(posedge clk) !rst_n_i |-> !ack_o;
	endproperty

	// ack is registered, so req was high on the edge before the rise
	property ack_rise_needs_req;
		@(posedge clk) disable iff (!rst_n_i) $rose(ack_o) |-> $past(req_i);
	endproperty

	property ack_held_until_req_low;
		@(posedge clk) disable iff (!rst_n_i) ack_o && req_i |=> ack_o;
	endproperty

	property rsp_stable_while_ack;
		@(posedge clk) disable iff (!rst_n_i) ack_o && $past(ack_o) |-> $stable(rsp_o);
	endproperty

	a_ack_low_in_reset: assert property (ack_low_in_reset)
		else $error("ack_o high during reset");
	a_ack_rise_needs_req: assert property (ack_rise_needs_req)
		else $error("ack_o rose without a request");
	a_ack_held: assert property (ack_held_until_req_low)
		else $error("ack_o dropped while req_i was high");
	a_rsp_stable: assert property (rsp_stable_while_ack)
		else $error("rsp_o changed while ack_o was high");

endmodule

bind int_div_top int_div_assert i_div_assert (
	.clk     (clk),
	.rst_n_i (rst_n_i),
	.req_i   (req_i),
	.ack_o   (ack_o),
	.rsp_o   (rsp_o)
);

`default_nettype wire

// File: testbench/tb_int_div.sv
`timescale 1ns/1ps
`default_nettype none

module tb_int_div;

	import div_pkg::*;

	localparam int ACK_LATENCY    = 67;
	localparam int N_DIRECTED     = 12;
	localparam int N_ZERO         = 4;
	localparam int N_MIN          = 2;
	localparam int N_RANDOM       = 150;
	localparam int N_BACKPRESS    = 9;
	localparam int N_REQS         = N_DIRECTED + N_ZERO + N_MIN + N_RANDOM + N_BACKPRESS;
	localparam int TIMEOUT_CYCLES = (N_REQS * 70 * 13) / 10;
	localparam logic [DIV_WIDTH-1:0] MIN_NEG = {1'b1, {(DIV_WIDTH-1){1'b0}}};

	logic                 clk;
	logic                 rst_n_i;
	logic                 req_i;
	div_req_t             req_data_i;
	logic                 ack_o;
	div_rsp_t             rsp_o;

	logic [31:0]          lfsr_q;
	div_rsp_t             exp_q[$];
	div_rsp_t             held_rsp;
	logic                 ack_prev;
	logic                 req_prev;
	int                   cycle_cnt = 0;
	int                   req_cycle = 0;
	int                   check_cnt = 0;
	int                   fail_cnt = 0;
	int                   fails_at_start = 0;
	int                   test_cnt = 0;
	int                   test_clean = 0;
	string                test_name;
	logic [DIV_WIDTH-1:0] r_op;
	logic [DIV_WIDTH-1:0] r_a;
	logic [DIV_WIDTH-1:0] r_b;
	logic [DIV_WIDTH-1:0] r_sel;
	logic [DIV_WIDTH-1:0] r_sh;
	div_req_t             bp_req;

	int_div_top i_dut (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.req_i      (req_i),
		.req_data_i (req_data_i),
		.ack_o      (ack_o),
		.rsp_o      (rsp_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	always @(negedge clk) begin
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic rand_bits(input int n, output logic [DIV_WIDTH-1:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			val    = {val[DIV_WIDTH-2:0], lfsr_q[0]};
		end
	endtask

	// truncating division on magnitudes, remainder takes the dividend's sign
	function automatic div_rsp_t ref_div(input div_req_t r);
		div_rsp_t             rsp;
		logic                 a_neg;
		logic                 b_neg;
		logic [DIV_WIDTH-1:0] a_mag;
		logic [DIV_WIDTH-1:0] b_mag;
		logic [DIV_WIDTH-1:0] q_mag;
		logic [DIV_WIDTH-1:0] r_mag;
		a_neg = (r.op == DIV_OP_SIGNED) && r.dividend[DIV_WIDTH-1];
		b_neg = (r.op == DIV_OP_SIGNED) && r.divisor[DIV_WIDTH-1];
		a_mag = a_neg ? (~r.dividend + 1'b1) : r.dividend;
		b_mag = b_neg ? (~r.divisor + 1'b1) : r.divisor;
		if (r.divisor == '0) begin
			rsp.quotient    = '1;
			rsp.remainder   = r.dividend;
			rsp.div_by_zero = 1'b1;
		end else begin
			q_mag           = a_mag / b_mag;
			r_mag           = a_mag % b_mag;
			rsp.quotient    = (a_neg != b_neg) ? (~q_mag + 1'b1) : q_mag;
			rsp.remainder   = a_neg ? (~r_mag + 1'b1) : r_mag;
			rsp.div_by_zero = 1'b0;
		end
		return rsp;
	endfunction

	function automatic div_req_t make_req(input div_op_e op, input logic [DIV_WIDTH-1:0] a,
			input logic [DIV_WIDTH-1:0] b);
		div_req_t r;
		r.op       = op;
		r.dividend = a;
		r.divisor  = b;
		return r;
	endfunction

	// four-phase req/ack, hold adds cycles of back-pressure after ack
	task automatic send_req(input div_req_t req, input div_rsp_t expected, input int hold);
		@(posedge clk);
		req_i      <= 1'b1;
		req_data_i <= req;
		exp_q.push_back(expected);
		@(negedge clk);
		while (!ack_o) begin
			@(negedge clk);
		end
		repeat (hold) @(negedge clk);
		@(posedge clk);
		req_i <= 1'b0;
		@(negedge clk);
		while (ack_o) begin
			@(negedge clk);
		end
	endtask

	task automatic run_case(input div_op_e op, input logic [DIV_WIDTH-1:0] a,
			input logic [DIV_WIDTH-1:0] b);
		send_req(make_req(op, a, b), ref_div(make_req(op, a, b)), 0);
	endtask

	task automatic run_zero_case(input div_op_e op, input logic [DIV_WIDTH-1:0] a);
		div_rsp_t expected;
		expected.quotient    = '1;
		expected.remainder   = a;
		expected.div_by_zero = 1'b1;
		send_req(make_req(op, a, '0), expected, 0);
	endtask

	task automatic compare_rsp();
		div_rsp_t expected;
		assert (exp_q.size() != 0) else begin
			$display("ack_o rose with no request outstanding");
			fail_cnt++;
		end
		if (exp_q.size() != 0) begin
			expected = exp_q.pop_front();
			check_cnt++;
			assert (rsp_o.quotient === expected.quotient) else begin
				$display("FAIL rsp_o.quotient: got %h, expected %h",
					rsp_o.quotient, expected.quotient);
				fail_cnt++;
			end
			assert (rsp_o.remainder === expected.remainder) else begin
				$display("FAIL rsp_o.remainder: got %h, expected %h",
					rsp_o.remainder, expected.remainder);
				fail_cnt++;
			end
			assert (rsp_o.div_by_zero === expected.div_by_zero) else begin
				$display("FAIL rsp_o.div_by_zero: got %h, expected %h",
					rsp_o.div_by_zero, expected.div_by_zero);
				fail_cnt++;
			end
			// req seen one negedge before the DUT samples it
			assert (cycle_cnt - req_cycle == ACK_LATENCY + 1) else begin
				$display("ack_o rose %0d cycles after the request was sampled instead of %0d",
					cycle_cnt - req_cycle - 1, ACK_LATENCY);
				fail_cnt++;
			end
		end
		held_rsp = rsp_o;
	endtask

	always @(negedge clk) begin
		if (!rst_n_i) begin
			ack_prev = 1'b0;
			req_prev = 1'b0;
		end else begin
			if (req_i && !req_prev) begin
				req_cycle = cycle_cnt;
			end
			if (ack_o && !ack_prev) begin
				assert (req_prev) else begin
					$display("ack_o rose while req_i was low");
					fail_cnt++;
				end
				compare_rsp();
			end else if (ack_o) begin
				assert (rsp_o === held_rsp) else begin
					$display("FAIL rsp_o: got %h, held %h", rsp_o, held_rsp);
					fail_cnt++;
				end
			end
			assert (!(ack_prev && req_prev && !ack_o)) else begin
				$display("ack_o fell while req_i was still high");
				fail_cnt++;
			end
			assert (!(ack_prev && !req_prev && ack_o)) else begin
				$display("ack_o stayed high after req_i had fallen");
				fail_cnt++;
			end
			ack_prev = ack_o;
			req_prev = req_i;
		end
	end

	task automatic begin_test(input string name);
		test_name      = name;
		fails_at_start = fail_cnt;
		test_cnt++;
	endtask

	task automatic end_test();
		if (fail_cnt == fails_at_start) begin
			test_clean++;
			$display("test %0d %s: ok", test_cnt, test_name);
		end else begin
			$display("test %0d %s: %0d errors", test_cnt, test_name, fail_cnt - fails_at_start);
		end
	endtask

	initial begin
		rst_n_i    = 1'b0;
		req_i      = 1'b0;
		req_data_i = '0;
		lfsr_q     = 32'd68;
		repeat (8) @(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);

		begin_test("directed");
		assert (ack_o === 1'b0) else begin
			$display("FAIL ack_o after reset: got %h, expected 0", ack_o);
			fail_cnt++;
		end
		assert (rsp_o === '0) else begin
			$display("FAIL rsp_o after reset: got %h, expected 0", rsp_o);
			fail_cnt++;
		end
		run_case(DIV_OP_SIGNED, 64'd18, 64'd3);
		run_case(DIV_OP_UNSIGNED, 64'd18, 64'd3);
		run_case(DIV_OP_SIGNED, -64'd18, 64'd3);
		run_case(DIV_OP_SIGNED, 64'd18, -64'd3);
		run_case(DIV_OP_SIGNED, -64'd18, -64'd3);
		run_case(DIV_OP_SIGNED, -64'd7, 64'd2);
		run_case(DIV_OP_SIGNED, 64'd7, -64'd2);
		run_case(DIV_OP_SIGNED, -64'd7, -64'd2);
		run_case(DIV_OP_UNSIGNED, -64'd18, 64'd3); // large unsigned dividend
		run_case(DIV_OP_UNSIGNED, '1, MIN_NEG);
		run_case(DIV_OP_SIGNED, 64'd5, 64'd7);
		run_case(DIV_OP_SIGNED, 64'd0, 64'd5);
		end_test();

		begin_test("divide by zero");
		run_zero_case(DIV_OP_SIGNED, 64'd18);
		run_zero_case(DIV_OP_SIGNED, -64'd18);
		run_zero_case(DIV_OP_UNSIGNED, 64'd18);
		run_zero_case(DIV_OP_UNSIGNED, '1);
		end_test();

		begin_test("most negative by minus one");
		send_req(make_req(DIV_OP_SIGNED, MIN_NEG, '1), '{MIN_NEG, '0, 1'b0}, 0);
		run_case(DIV_OP_UNSIGNED, MIN_NEG, '1);
		end_test();

		begin_test("random");
		for (int i = 0; i < N_RANDOM; i++) begin
			rand_bits(1, r_op);
			rand_bits(DIV_WIDTH, r_a);
			rand_bits(DIV_WIDTH, r_b);
			rand_bits(1, r_sel);
			if (r_sel[0]) begin
				rand_bits(6, r_sh); // small divisors
				r_b = r_b >> r_sh[5:0];
			end
			run_case(div_op_e'(r_op[0]), r_a, r_b);
		end
		end_test();

		begin_test("latency and back-pressure");
		for (int i = 0; i < N_BACKPRESS - 1; i++) begin
			rand_bits(1, r_op);
			rand_bits(DIV_WIDTH, r_a);
			rand_bits(DIV_WIDTH, r_b);
			rand_bits(5, r_sh);
			bp_req = make_req(div_op_e'(r_op[0]), r_a, r_b);
			send_req(bp_req, ref_div(bp_req), int'(r_sh % 21));
		end
		run_case(DIV_OP_SIGNED, -64'd18, 64'd3);
		end_test();

		repeat (2) @(negedge clk);
		assert (exp_q.size() == 0) else begin
			$display("%0d responses never arrived", exp_q.size());
			fail_cnt++;
		end
		$display("%0d of %0d tests clean, %0d checks, %0d failures",
			test_clean, test_cnt, check_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
hdl/div_pkg.sv
hdl/div_ctrl.sv
hdl/div_step_counter.sv
hdl/div_sign_unit.sv
hdl/div_datapath.sv
hdl/int_div_top.sv
testbench/int_div_assert.sv
testbench/tb_int_div.sv
